// File: axi_line_config.svh
`ifndef AXI_LINE_CONFIG_SVH
`define AXI_LINE_CONFIG_SVH

// bus and line geometry
`define ADDR_W          32
`define WORD_W          32
`define LINE_WORDS      4
`define BEAT_W          2        // enough to index LINE_WORDS

// axi field widths
`define ID_W            4
`define LEN_W           4
`define SIZE_W          3
`define BURST_W         2
`define LOCK_W          2
`define CACHE_W         4
`define PROT_W          3
`define RESP_W          2
`define STRB_W          (`WORD_W / 8)

// fixed values driven on every burst
`define AXI_DATA_ID     4'd1
`define AXI_LEN         4'd3     // four beats
`define AXI_SIZE        3'd2     // 4 bytes per beat
`define AXI_BURST_INCR  2'd1

`endif

// File: axi_line_pkg.sv
`include "axi_line_config.svh"

package axi_line_pkg;

    typedef logic [`WORD_W-1:0] word_t;

    // word 0 is the lowest address and the lsb end
    typedef word_t [`LINE_WORDS-1:0] line_t;

    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
    } rd_req_t;

    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        line_t              line;
    } wr_req_t;

    // shared by ar and aw
    typedef struct packed {
        logic [`ID_W-1:0]    id;
        logic [`ADDR_W-1:0]  addr;
        logic [`LEN_W-1:0]   len;
        logic [`SIZE_W-1:0]  size;
        logic [`BURST_W-1:0] burst;
        logic [`LOCK_W-1:0]  lock;
        logic [`CACHE_W-1:0] cache;
        logic [`PROT_W-1:0]  prot;
    } addr_chan_t;

    typedef struct packed {
        logic [`ID_W-1:0]   id;
        word_t              data;
        logic [`STRB_W-1:0] strb;
        logic               last;
    } w_chan_t;

    typedef struct packed {
        logic [`ID_W-1:0]   id;
        word_t              data;
        logic [`RESP_W-1:0] resp;
        logic               last;
    } r_chan_t;

    typedef struct packed {
        logic [`ID_W-1:0]   id;
        logic [`RESP_W-1:0] resp;
    } b_chan_t;

endpackage

// File: beat_counter.sv
`timescale 1ns/1ps
`include "axi_line_config.svh"

module beat_counter (
    input  logic               clk,
    input  logic               resetn,
    input  logic               beat,
    output logic [`BEAT_W-1:0] beat_idx,
    output logic               last_beat
);

    // final beat of a line
    assign last_beat = (beat_idx == `BEAT_W'(`LINE_WORDS - 1));

    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat_idx <= '0;
        end else if (beat) begin
            if (last_beat) begin
                beat_idx <= '0;              // ready for the next burst
            end else begin
                beat_idx <= beat_idx + 1'b1;
            end
        end
    end

endmodule

// File: burst_fsm.sv
`timescale 1ns/1ps

module burst_fsm (
    input  logic clk,
    input  logic resetn,
    // read side
    input  logic rd_req_valid,
    output logic rd_req_ready,
    output logic rd_accept,
    output logic arvalid,
    input  logic arready,
    input  logic rvalid,
    output logic rready,
    output logic rd_beat,
    input  logic rd_last_beat,
    output logic rd_ret_valid,
    // write side
    input  logic wr_req_valid,
    output logic wr_req_ready,
    output logic wr_accept,
    output logic awvalid,
    input  logic awready,
    output logic wvalid,
    input  logic wready,
    output logic wr_beat,
    input  logic wr_last_beat,
    input  logic bvalid,
    output logic bready,
    output logic wr_done
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_t;

    rd_state_t rd_state, rd_next;
    wr_state_t wr_state, wr_next;

    // handshake controls straight from the state
    assign rd_req_ready = (rd_state == RD_IDLE);
    assign rd_accept    = rd_req_valid && rd_req_ready;
    assign arvalid      = (rd_state == RD_ADDR);
    assign rready       = (rd_state == RD_DATA);
    assign rd_beat      = rvalid && rready;     // one R beat taken

    assign wr_req_ready = (wr_state == WR_IDLE);
    assign wr_accept    = wr_req_valid && wr_req_ready;
    assign awvalid      = (wr_state == WR_ADDR);
    assign wvalid       = (wr_state == WR_DATA);
    assign wr_beat      = wvalid && wready;
    assign bready       = (wr_state == WR_RESP);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_state <= RD_IDLE;
            wr_state <= WR_IDLE;
        end else begin
            rd_state <= rd_next;
            wr_state <= wr_next;
        end
    end

    always_comb begin
        rd_next = rd_state;
        case (rd_state)
            RD_IDLE: if (rd_accept) rd_next = RD_ADDR;
            RD_ADDR: if (arready) rd_next = RD_DATA;
            RD_DATA: if (rd_beat && rd_last_beat) rd_next = RD_IDLE;   // own count, not rlast
            default: rd_next = RD_IDLE;
        endcase
    end

    always_comb begin
        wr_next = wr_state;
        case (wr_state)
            WR_IDLE: if (wr_accept) wr_next = WR_ADDR;
            WR_ADDR: if (awready) wr_next = WR_DATA;
            WR_DATA: if (wr_beat && wr_last_beat) wr_next = WR_RESP;
            WR_RESP: if (bvalid) wr_next = WR_IDLE;
            default: wr_next = WR_IDLE;
        endcase
    end

    // completion pulses, one cycle, on the way back to idle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_ret_valid <= 1'b0;
            wr_done      <= 1'b0;
        end else begin
            rd_ret_valid <= (rd_state == RD_DATA) && rd_beat && rd_last_beat;
            wr_done      <= (wr_state == WR_RESP) && bvalid;
        end
    end

endmodule

// File: read_line_buffer.sv
`timescale 1ns/1ps
`include "axi_line_config.svh"

module read_line_buffer (
    input  logic                    clk,
    input  logic                    resetn,
    input  axi_line_pkg::rd_req_t   rd_req,
    input  logic                    rd_accept,
    input  axi_line_pkg::r_chan_t   r,
    input  logic                    rd_beat,
    input  logic [`BEAT_W-1:0]      beat_idx,
    output axi_line_pkg::addr_chan_t ar,
    output axi_line_pkg::line_t     rd_line
);

    logic [`ADDR_W-1:0] rd_addr;

    // address must stay put until the AR handshake
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_addr <= '0;
        end else if (rd_accept) begin
            rd_addr <= rd_req.addr;
        end
    end

    always_comb begin
        ar       = '0;           // lock, cache, prot stay zero
        ar.id    = `AXI_DATA_ID;
        ar.addr  = rd_addr;
        ar.len   = `AXI_LEN;
        ar.size  = `AXI_SIZE;
        ar.burst = `AXI_BURST_INCR;
    end

    // each beat lands in its own word slot
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_line <= '0;
        end else if (rd_beat) begin
            rd_line[beat_idx] <= r.data;
        end
    end

endmodule

// File: write_line_buffer.sv
`timescale 1ns/1ps
`include "axi_line_config.svh"

module write_line_buffer (
    input  logic                     clk,
    input  logic                     resetn,
    input  axi_line_pkg::wr_req_t    wr_req,
    input  logic                     wr_accept,
    input  logic [`BEAT_W-1:0]       beat_idx,
    input  logic                     last_beat,
    output axi_line_pkg::addr_chan_t aw,
    output axi_line_pkg::w_chan_t    w
);

    axi_line_pkg::wr_req_t held;     // address and line for the whole burst

    always_ff @(posedge clk) begin
        if (!resetn) begin
            held <= '0;
        end else if (wr_accept) begin
            held <= wr_req;
        end
    end

    always_comb begin
        aw       = '0;
        aw.id    = `AXI_DATA_ID;
        aw.addr  = held.addr;
        aw.len   = `AXI_LEN;
        aw.size  = `AXI_SIZE;
        aw.burst = `AXI_BURST_INCR;
    end

    // data follows the beat counter, so it holds while wready is low
    always_comb begin
        w      = '0;
        w.id   = `AXI_DATA_ID;
        w.data = held.line[beat_idx];
        w.strb = '1;             // full line writes only
        w.last = last_beat;
    end

endmodule

// File: axi_line_bridge.sv
`timescale 1ns/1ps
`include "axi_line_config.svh"

module axi_line_bridge (
    input  logic                     clk,
    input  logic                     resetn,
    // cache side
    input  axi_line_pkg::rd_req_t    rd_req,
    input  logic                     rd_req_valid,
    output logic                     rd_req_ready,
    input  axi_line_pkg::wr_req_t    wr_req,
    input  logic                     wr_req_valid,
    output logic                     wr_req_ready,
    output axi_line_pkg::line_t      rd_line,
    output logic                     rd_ret_valid,
    output logic                     wr_done,
    // axi master
    output axi_line_pkg::addr_chan_t ar,
    output logic                     arvalid,
    input  logic                     arready,
    input  axi_line_pkg::r_chan_t    r,
    input  logic                     rvalid,
    output logic                     rready,
    output axi_line_pkg::addr_chan_t aw,
    output logic                     awvalid,
    input  logic                     awready,
    output axi_line_pkg::w_chan_t    w,
    output logic                     wvalid,
    input  logic                     wready,
    input  axi_line_pkg::b_chan_t    b,       // response code not acted on
    input  logic                     bvalid,
    output logic                     bready
);

    logic               rd_accept;
    logic               wr_accept;
    logic               rd_beat;
    logic               wr_beat;
    logic [`BEAT_W-1:0] rd_beat_idx;
    logic [`BEAT_W-1:0] wr_beat_idx;
    logic               rd_last_beat;
    logic               wr_last_beat;

    burst_fsm u_fsm (
        .clk          (clk),
        .resetn       (resetn),
        .rd_req_valid (rd_req_valid),
        .rd_req_ready (rd_req_ready),
        .rd_accept    (rd_accept),
        .arvalid      (arvalid),
        .arready      (arready),
        .rvalid       (rvalid),
        .rready       (rready),
        .rd_beat      (rd_beat),
        .rd_last_beat (rd_last_beat),
        .rd_ret_valid (rd_ret_valid),
        .wr_req_valid (wr_req_valid),
        .wr_req_ready (wr_req_ready),
        .wr_accept    (wr_accept),
        .awvalid      (awvalid),
        .awready      (awready),
        .wvalid       (wvalid),
        .wready       (wready),
        .wr_beat      (wr_beat),
        .wr_last_beat (wr_last_beat),
        .bvalid       (bvalid),
        .bready       (bready),
        .wr_done      (wr_done)
    );

    beat_counter u_rd_count (
        .clk       (clk),
        .resetn    (resetn),
        .beat      (rd_beat),
        .beat_idx  (rd_beat_idx),
        .last_beat (rd_last_beat)
    );

    beat_counter u_wr_count (
        .clk       (clk),
        .resetn    (resetn),
        .beat      (wr_beat),
        .beat_idx  (wr_beat_idx),
        .last_beat (wr_last_beat)    // also becomes wlast
    );

    read_line_buffer u_rd_buf (
        .clk       (clk),
        .resetn    (resetn),
        .rd_req    (rd_req),
        .rd_accept (rd_accept),
        .r         (r),
        .rd_beat   (rd_beat),
        .beat_idx  (rd_beat_idx),
        .ar        (ar),
        .rd_line   (rd_line)
    );

    write_line_buffer u_wr_buf (
        .clk       (clk),
        .resetn    (resetn),
        .wr_req    (wr_req),
        .wr_accept (wr_accept),
        .beat_idx  (wr_beat_idx),
        .last_beat (wr_last_beat),
        .aw        (aw),
        .w         (w)
    );

endmodule

// File: tb_axi_mem.sv
`timescale 1ns/1ps

module tb_axi_mem (
    input  logic                     clk,
    input  logic                     stall_en,
    input  axi_line_pkg::addr_chan_t ar,
    input  logic                     arvalid,
    output logic                     arready,
    output axi_line_pkg::r_chan_t    r,
    output logic                     rvalid,
    input  logic                     rready,
    input  axi_line_pkg::addr_chan_t aw,
    input  logic                     awvalid,
    output logic                     awready,
    input  axi_line_pkg::w_chan_t    w,
    input  logic                     wvalid,
    output logic                     wready,
    output axi_line_pkg::b_chan_t    b,
    output logic                     bvalid,
    input  logic                     bready,
    output logic                     proto_err
);

    logic [31:0] mem [0:63];      // word addressed, byte address bits 7:2
    logic [31:0] lfsr;
    logic [5:0]  rd_idx, wr_idx;
    logic [2:0]  rd_left, wr_left;     // beats still to move
    logic        rd_busy, wr_busy;
    logic        nxt_ar, nxt_r, nxt_aw, nxt_w, nxt_b;

    // galois step, one call per bit taken
    function automatic logic take_bit();
        take_bit = lfsr[0];
        lfsr     = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
    endfunction

    function automatic logic go_bit();
        go_bit = stall_en ? take_bit() : 1'b1;
    endfunction

    function automatic logic chan_ok(input axi_line_pkg::addr_chan_t c);
        chan_ok = (c.id == 4'd1) && (c.len == 4'd3) && (c.size == 3'd2) && (c.burst == 2'd1)
                  && (c.addr[3:0] == 4'h0) && (c.addr < 32'h100);
    endfunction

    task automatic flag_violation(input string what);
        $display("memory model: protocol violation, %s (time %0t ns)", what, $time);
        proto_err = 1'b1;
    endtask

    initial begin
        for (int i = 0; i < 64; i++)
            mem[i] = {16'(4 * i) ^ 16'hbeef, 16'(4 * i)};
        lfsr      = 32'hea53cd99;
        rd_busy   = 1'b0;
        wr_busy   = 1'b0;
        rd_left   = '0;
        wr_left   = '0;
        rd_idx    = '0;
        wr_idx    = '0;
        arready   = 1'b0;
        rvalid    = 1'b0;
        awready   = 1'b0;
        wready    = 1'b0;
        bvalid    = 1'b0;
        r         = '0;
        b         = '0;
        proto_err = 1'b0;
    end

    always @(posedge clk) begin
        // handshakes as seen at this edge
        if (arvalid && arready) begin
            if (!chan_ok(ar))
                flag_violation("bad AR fields");
            rd_idx  = ar.addr[7:2];
            rd_left = 3'd4;
            rd_busy = 1'b1;
        end
        if (rvalid && rready) begin
            rd_idx  = rd_idx + 1'b1;
            rd_left = rd_left - 1'b1;
            rd_busy = (rd_left != 3'd0);
        end
        if (awvalid && awready) begin
            if (!chan_ok(aw))
                flag_violation("bad AW fields");
            wr_idx  = aw.addr[7:2];
            wr_left = 3'd4;
            wr_busy = 1'b1;
        end
        if (wvalid && wready) begin
            if (w.last != (wr_left == 3'd1))
                flag_violation("wlast on the wrong W beat");
            if (w.strb != 4'hf)
                flag_violation("partial write strobe");
            mem[wr_idx] = w.data;
            wr_idx      = wr_idx + 1'b1;
            wr_left     = wr_left - 1'b1;
        end
        if (bvalid && bready)
            wr_busy = 1'b0;

        // readies answer a valid seen here, valids hold until taken
        nxt_ar = (arvalid && !rd_busy) ? go_bit() : 1'b0;
        nxt_aw = (awvalid && !wr_busy) ? go_bit() : 1'b0;
        nxt_w  = (wr_busy && wr_left != 3'd0) ? go_bit() : 1'b0;
        nxt_r  = rvalid;
        if (!(rvalid && !rready))
            nxt_r = (rd_busy && rd_left != 3'd0) ? go_bit() : 1'b0;
        nxt_b  = bvalid;
        if (!(bvalid && !bready))
            nxt_b = (wr_busy && wr_left == 3'd0) ? go_bit() : 1'b0;

        #2;
        arready = nxt_ar;
        awready = nxt_aw;
        wready  = nxt_w;
        rvalid  = nxt_r;
        bvalid  = nxt_b;
        r       = '0;
        r.id    = 4'd1;
        r.data  = mem[rd_idx];
        r.last  = (rd_left == 3'd1);
        b       = '0;
        b.id    = 4'd1;                // okay response
    end

endmodule

// File: tb_axi_line_bridge.sv
`timescale 1ns/1ps
`include "axi_line_config.svh"

module tb_axi_line_bridge;

    localparam int N_TXN     = 17;
    localparam int MAX_CYCLE = 40 * N_TXN + 100;

    logic clk, resetn, stall_en, proto_err;
    logic rd_req_valid, rd_req_ready, wr_req_valid, wr_req_ready;
    logic rd_ret_valid, wr_done;
    logic arvalid, arready, rvalid, rready, awvalid, awready;
    logic wvalid, wready, bvalid, bready;
    axi_line_pkg::rd_req_t    rd_req;
    axi_line_pkg::wr_req_t    wr_req;
    axi_line_pkg::line_t      rd_line;
    axi_line_pkg::addr_chan_t ar, aw;
    axi_line_pkg::r_chan_t    r;
    axi_line_pkg::w_chan_t    w;
    axi_line_pkg::b_chan_t    b;
    axi_line_pkg::word_t      shadow [0:63];    // expected memory contents
    int cycle_count = 0;

    axi_line_bridge DUT (.*);
    tb_axi_mem mem_model (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLE) begin
            $display("timeout: tests still running after %0d cycles", MAX_CYCLE);
            stop_run();
        end
    end

    always @(posedge proto_err) begin
        $display("the AXI memory model saw a protocol violation");
        stop_run();
    end

    task automatic check_line(input axi_line_pkg::line_t got, exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s, got %h expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input logic got, exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s, got %b expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_addr_chan(input axi_line_pkg::addr_chan_t got, exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s, got %h expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_cycles(input int got, exp, input string what);
        if (got != exp) begin
            $display("[ERROR] %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
            stop_run();
        end
    endtask

    // memory fill, depends on the whole byte address
    function automatic axi_line_pkg::word_t fill_word(input logic [31:0] addr);
        fill_word = {addr[15:0] ^ 16'hbeef, addr[15:0]};
    endfunction

    function automatic axi_line_pkg::line_t make_line(input logic [31:0] addr, input logic [7:0] tag);
        for (int k = 0; k < `LINE_WORDS; k++)
            make_line[k] = {tag, 8'h5c, addr[15:0] + 16'(4 * k)};
    endfunction

    // tasks below start and end 2 ns after a rising edge
    task automatic issue_read(input logic [31:0] addr);
        rd_req.addr  = addr;
        rd_req_valid = 1'b1;
        @(posedge clk);
        while (!rd_req_ready)
            @(posedge clk);
        #2 rd_req_valid = 1'b0;
    endtask

    task automatic issue_write(input logic [31:0] addr, input axi_line_pkg::line_t line);
        wr_req.addr  = addr;
        wr_req.line  = line;
        wr_req_valid = 1'b1;
        @(posedge clk);
        while (!wr_req_ready)
            @(posedge clk);
        #2 wr_req_valid = 1'b0;
    endtask

    // edges from acceptance to the return pulse, line checked against the shadow
    task automatic await_read(input logic [31:0] addr, output int cycles);
        axi_line_pkg::line_t exp;
        for (int k = 0; k < `LINE_WORDS; k++)
            exp[k] = shadow[addr[7:2] + k];
        @(posedge clk);
        cycles = 1;
        while (!rd_ret_valid) begin
            check_flag(rd_req_ready, 1'b0, "rd_req_ready while the read runs");
            @(posedge clk);
            cycles++;
        end
        check_line(rd_line, exp, $sformatf("line read at %h", addr));
        #2;
    endtask

    task automatic await_write(input logic [31:0] addr, input axi_line_pkg::line_t line,
                               output int cycles);
        int beats;
        beats = 0;
        @(posedge clk);
        cycles = 1;
        while (!wr_done) begin
            check_flag(wr_req_ready, 1'b0, "wr_req_ready while the write runs");
            if (wvalid && wready) begin
                beats++;
                check_flag(w.last, beats == 4, "wlast on this W beat");
            end
            @(posedge clk);
            cycles++;
        end
        for (int k = 0; k < `LINE_WORDS; k++)
            shadow[addr[7:2] + k] = line[k];
        #2;
    endtask

    task automatic read_and_wait(input logic [31:0] addr);
        int cycles;
        issue_read(addr);
        await_read(addr, cycles);
    endtask

    task automatic write_and_wait(input logic [31:0] addr, input axi_line_pkg::line_t line);
        int cycles;
        issue_write(addr, line);
        await_write(addr, line, cycles);
    endtask

    task automatic test_reset();
        check_flag(rd_req_ready, 1'b1, "rd_req_ready after reset");
        check_flag(wr_req_ready, 1'b1, "wr_req_ready after reset");
        check_flag(arvalid, 1'b0, "arvalid after reset");
        check_flag(awvalid, 1'b0, "awvalid after reset");
        check_flag(wvalid, 1'b0, "wvalid after reset");
        check_flag(rready, 1'b0, "rready after reset");
        check_flag(bready, 1'b0, "bready after reset");
        check_flag(rd_ret_valid, 1'b0, "rd_ret_valid after reset");
        check_flag(wr_done, 1'b0, "wr_done after reset");
    endtask

    task automatic test_plain_read();
        axi_line_pkg::addr_chan_t exp;
        int cycles;
        exp       = '0;
        exp.id    = 4'd1;
        exp.addr  = 32'h40;
        exp.len   = 4'd3;
        exp.size  = 3'd2;
        exp.burst = 2'd1;       // incrementing
        stall_en  = 1'b0;
        issue_read(32'h40);
        check_flag(arvalid, 1'b1, "arvalid the cycle after accept");
        check_addr_chan(ar, exp, "AR payload");
        await_read(32'h40, cycles);
        check_cycles(cycles, 7, "read accept to rd_ret_valid");
    endtask

    task automatic test_write_readback();
        axi_line_pkg::addr_chan_t exp;
        axi_line_pkg::line_t line;
        int cycles;
        exp       = '0;
        exp.id    = 4'd1;
        exp.addr  = 32'h80;
        exp.len   = 4'd3;
        exp.size  = 3'd2;
        exp.burst = 2'd1;
        stall_en  = 1'b0;
        line      = make_line(32'h80, 8'h01);
        issue_write(32'h80, line);
        check_flag(awvalid, 1'b1, "awvalid the cycle after accept");
        check_addr_chan(aw, exp, "AW payload");
        await_write(32'h80, line, cycles);
        check_cycles(cycles, 8, "write accept to wr_done");
        read_and_wait(32'h80);
    endtask

    task automatic test_stalled_traffic();
        stall_en = 1'b1;
        for (int i = 0; i < 4; i++)
            write_and_wait(32'h20 + 32'(16 * i), make_line(32'h20 + 32'(16 * i), 8'(16 + i)));
        for (int i = 0; i < 4; i++)
            read_and_wait(32'h20 + 32'(16 * i));
        write_and_wait(32'h30, make_line(32'h30, 8'h20));
        read_and_wait(32'h30);
        read_and_wait(32'he0);  // never written
    endtask

    // read of one line and write of another, taken on the same edge
    task automatic test_overlap();
        axi_line_pkg::line_t line;
        int rd_cycles, wr_cycles;
        stall_en     = 1'b1;
        line         = make_line(32'hc0, 8'h30);
        rd_req.addr  = 32'hb0;
        wr_req.addr  = 32'hc0;
        wr_req.line  = line;
        rd_req_valid = 1'b1;
        wr_req_valid = 1'b1;
        @(posedge clk);
        check_flag(rd_req_ready, 1'b1, "read taken with the write");
        check_flag(wr_req_ready, 1'b1, "write taken with the read");
        #2;
        rd_req_valid = 1'b0;
        wr_req_valid = 1'b0;
        fork
            await_read(32'hb0, rd_cycles);
            await_write(32'hc0, line, wr_cycles);
        join
        read_and_wait(32'hc0);
    endtask

    initial begin
        resetn       = 1'b0;
        stall_en     = 1'b0;
        rd_req       = '0;
        rd_req_valid = 1'b0;
        wr_req       = '0;
        wr_req_valid = 1'b0;
        for (int i = 0; i < 64; i++)
            shadow[i] = fill_word(32'(4 * i));
        repeat (8) @(posedge clk);
        #2 resetn = 1'b1;
        test_reset();
        test_plain_read();
        test_write_readback();
        test_stalled_traffic();
        test_overlap();
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: build.f
+incdir+.
axi_line_pkg.sv
beat_counter.sv
burst_fsm.sv
read_line_buffer.sv
write_line_buffer.sv
axi_line_bridge.sv
tb_axi_mem.sv
tb_axi_line_bridge.sv
